//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bp_predictor_tb
FILELIST  ?= bp_predictor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TB PASSED

.PHONY: sim clean

# The log is searched for the pass line, so a failing run makes grep fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bp_predictor.f
rtl/bp_pkg.sv
rtl/bp_btb_table.sv
rtl/bp_lookup_stage.sv
rtl/bp_seq_out.sv
rtl/bp_predictor.sv
dv/bp_predictor_properties.sv
dv/bp_predictor_tb.sv

//--- dv/bp_predictor_properties.sv
/*
 * Concurrent checks on the response handshake and the reset state.
 * Attached to every bp_predictor instance through bind.
 */

`default_nettype none

module bp_predictor_properties (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  logic                         i_bp_ready,
    input  logic                         o_bp_req_ready,
    input  logic                         o_bp_valid,
    input  bp_pkg::bp_seq_t              o_bp_seq,
    input  logic [bp_pkg::BP_DEPTH-1:0]  o_bp_hit
);

    timeunit 1ns;
    timeprecision 1ps;

    // No response can be pending while or right after reset
    a_idle_in_reset: assert property (@(posedge i_clk) !i_nrst |-> !o_bp_valid)
        else $error("response valid during reset");

    a_idle_after_reset: assert property (@(posedge i_clk) $rose(i_nrst) |-> !o_bp_valid)
        else $error("response valid in the first cycle after reset");

    // A stalled response keeps its contents until it is taken
    a_held_on_stall: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_bp_valid && !i_bp_ready) |=>
            (o_bp_valid && $stable(o_bp_seq) && $stable(o_bp_hit)))
        else $error("stalled response changed or dropped");

    a_req_ready: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_bp_req_ready == !(o_bp_valid && !i_bp_ready))
        else $error("request ready does not follow the output stall");

endmodule : bp_predictor_properties

bind bp_predictor bp_predictor_properties i_props (
    .i_clk          (i_clk),
    .i_nrst         (i_nrst),
    .i_bp_ready     (i_bp_ready),
    .o_bp_req_ready (o_bp_req_ready),
    .o_bp_valid     (o_bp_valid),
    .o_bp_seq       (o_bp_seq),
    .o_bp_hit       (o_bp_hit)
);

`default_nettype wire

//--- dv/bp_predictor_tb.sv
/*
 * Testbench for the branch-target prediction unit.
 * Directed phases and a seeded random phase, each response compared against
 * a move-to-front BTB model kept in the testbench.
 */

`default_nettype none

module bp_predictor_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int            CLK_PERIOD  = 100;
    localparam int            RST_CYCLES  = 10;
    localparam int            NUM_PHASES  = 6;
    localparam int            PHASE_LIMIT = 400;    // Upper bound of cycles per phase
    localparam int            RAND_CYCLES = 300;
    localparam int            POOL_SIZE   = 16;
    localparam bp_pkg::addr_t POOL_BASE   = 32'h0000_1000;

    typedef struct packed {
        bp_pkg::bp_seq_t              seq;
        logic [bp_pkg::BP_DEPTH-1:0]  hit;
    } resp_t;

    logic                         i_clk = 1'b0;
    logic                         i_nrst;
    logic                         i_flush;
    bp_pkg::bp_update_t           i_upd;
    logic                         i_bp_req;
    bp_pkg::addr_t                i_bp_pc;
    logic                         o_bp_req_ready;
    logic                         o_bp_valid;
    bp_pkg::bp_seq_t              o_bp_seq;
    logic [bp_pkg::BP_DEPTH-1:0]  o_bp_hit;
    logic                         i_bp_ready;

    bp_pkg::btb_entry_t  model_tbl [bp_pkg::BTB_SIZE];
    resp_t               exp_q [$];     // Accepted requests awaiting their response
    int                  err_cnt   = 0;
    int                  check_cnt = 0;
    int                  resp_cnt  = 0;

    bp_predictor i_dut (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic bp_pkg::addr_t addr_at(input int idx);
        return POOL_BASE + bp_pkg::addr_t'(idx * 4);
    endfunction

    // Small pool so that fall-through addresses often land on stored sources
    function automatic bp_pkg::addr_t pick_addr();
        return addr_at(int'($urandom % POOL_SIZE));
    endfunction

    function automatic void clear_model();
        for (int i = 0; i < bp_pkg::BTB_SIZE; i++) begin
            model_tbl[i] = '{pc: '1, npc: '0, exec: 1'b0};
        end
    endfunction

    function automatic void apply_update(input bp_pkg::bp_update_t u);
        int   pos;
        logic found;
        pos   = bp_pkg::BTB_SIZE - 1;    // Oldest line drops on a miss
        found = 1'b0;
        for (int i = bp_pkg::BTB_SIZE - 1; i >= 0; i--) begin
            if (model_tbl[i].pc == u.pc) begin
                pos   = i;
                found = 1'b1;
            end
        end
        if (found && model_tbl[pos].exec && !u.e) begin
            return;
        end
        for (int i = pos; i > 0; i--) begin
            model_tbl[i] = model_tbl[i-1];
        end
        model_tbl[0] = '{pc: u.pc, npc: u.npc, exec: u.e};
    endfunction

    function automatic resp_t predict_seq(input bp_pkg::addr_t start);
        resp_t         r;
        bp_pkg::addr_t a;
        logic          found;
        r.hit            = '0;
        r.seq[0].npc     = start;
        r.seq[0].exec    = 1'b0;
        a                = start;
        for (int k = 1; k < bp_pkg::BP_DEPTH; k++) begin
            found = 1'b0;
            for (int i = 0; i < bp_pkg::BTB_SIZE; i++) begin
                if (!found && model_tbl[i].pc == a) begin    // Most recent line first
                    found         = 1'b1;
                    r.seq[k].npc  = model_tbl[i].npc;
                    r.seq[k].exec = model_tbl[i].exec;
                end
            end
            if (!found) begin
                r.seq[k].npc  = a + 32'd4;
                r.seq[k].exec = 1'b0;
            end
            r.hit[k] = found;
            a        = r.seq[k].npc;
        end
        return r;
    endfunction

    // Inputs are driven after the rising edge, so the falling edge sees a settled cycle
    always @(negedge i_clk) begin
        resp_t exp_r;
        logic  pending;
        logic  ready_exp;
        if (i_nrst) begin
            pending   = exp_q.size() != 0;
            ready_exp = !(pending && !i_bp_ready);    // Held response blocks new requests
            check_cnt++;
            assert (o_bp_valid == pending) else begin
                err_cnt++;
                $display("error: o_bp_valid expected %h got %h", pending, o_bp_valid);
            end
            assert (o_bp_req_ready == ready_exp) else begin
                err_cnt++;
                $display("error: o_bp_req_ready expected %h got %h",
                         ready_exp, o_bp_req_ready);
            end
            if (pending && i_bp_ready) begin
                exp_r = exp_q.pop_front();
                resp_cnt++;
                assert (o_bp_seq == exp_r.seq) else begin
                    err_cnt++;
                    $display("error: o_bp_seq expected %h got %h", exp_r.seq, o_bp_seq);
                end
                assert (o_bp_hit == exp_r.hit) else begin
                    err_cnt++;
                    $display("error: o_bp_hit expected %h got %h", exp_r.hit, o_bp_hit);
                end
            end
            if (i_bp_req && ready_exp) begin
                exp_q.push_back(predict_seq(i_bp_pc));    // Table as it is before this edge
            end
            if (i_flush) begin
                clear_model();
            end else if (i_upd.we) begin
                apply_update(i_upd);
            end
        end
    end

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic send_update(input bp_pkg::addr_t pc, input bp_pkg::addr_t npc,
                               input logic e);
        i_upd = '{we: 1'b1, e: e, pc: pc, npc: npc};
        next_cycle();
        i_upd.we = 1'b0;
    endtask

    task automatic send_request(input bp_pkg::addr_t pc);
        logic taken;
        i_bp_req = 1'b1;
        i_bp_pc  = pc;
        do begin
            @(negedge i_clk);
            taken = o_bp_req_ready;
            next_cycle();
        end while (!taken);
        i_bp_req = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    initial begin : watchdog
        #(CLK_PERIOD * (RST_CYCLES + NUM_PHASES * PHASE_LIMIT));
        $display("timeout: the test phases did not complete within %0d cycles",
                 RST_CYCLES + NUM_PHASES * PHASE_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'hc64d_e2cb));
        i_nrst     = 1'b0;
        i_flush    = 1'b0;
        i_upd      = '0;
        i_bp_req   = 1'b0;
        i_bp_pc    = '0;
        i_bp_ready = 1'b1;
        clear_model();
        repeat (RST_CYCLES) @(posedge i_clk);
        #1;
        i_nrst = 1'b1;

        // Every slot falls through on an empty table
        repeat (8) send_request(pick_addr());
        wait_drain();

        // Chain A to B to C and then a loop back to A
        send_update(addr_at(2), addr_at(9), 1'b1);
        send_update(addr_at(9), addr_at(5), 1'b0);
        send_request(addr_at(2));
        send_update(addr_at(5), addr_at(2), 1'b1);
        send_request(addr_at(2));
        send_request(addr_at(9));
        wait_drain();

        // One more source than lines and then a repeat of a middle source
        for (int i = 0; i <= bp_pkg::BTB_SIZE; i++) begin
            send_update(addr_at(i), addr_at(POOL_SIZE - 1 - i), 1'b1);
        end
        send_request(addr_at(0));
        send_update(addr_at(4), addr_at(11), 1'b1);
        send_request(addr_at(4));
        send_request(addr_at(1));
        wait_drain();

        // Pre-decoded target must not beat an executed one
        send_update(addr_at(13), addr_at(3), 1'b1);
        send_update(addr_at(13), addr_at(7), 1'b0);
        send_request(addr_at(13));
        send_update(addr_at(13), addr_at(10), 1'b1);
        send_request(addr_at(13));
        wait_drain();

        // Flush wins over a write in the same cycle
        i_flush = 1'b1;
        i_upd   = '{we: 1'b1, e: 1'b1, pc: addr_at(6), npc: addr_at(12)};
        next_cycle();
        i_flush  = 1'b0;
        i_upd.we = 1'b0;
        repeat (6) send_request(pick_addr());
        wait_drain();

        // Random traffic with consumer stalls
        for (int c = 0; c < RAND_CYCLES; c++) begin
            i_bp_ready = ($urandom % 4) != 0;
            i_bp_req   = ($urandom % 2) != 0;
            i_bp_pc    = pick_addr();
            i_upd.we   = ($urandom % 3) == 0;
            i_upd.e    = ($urandom % 2) != 0;
            i_upd.pc   = pick_addr();
            i_upd.npc  = pick_addr();
            i_flush    = ($urandom % 64) == 0;
            next_cycle();
        end
        i_bp_req   = 1'b0;
        i_upd.we   = 1'b0;
        i_flush    = 1'b0;
        i_bp_ready = 1'b1;
        wait_drain();
        next_cycle();

        $display("checks %0d, responses %0d, errors %0d", check_cnt, resp_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : bp_predictor_tb

`default_nettype wire

//--- rtl/bp_btb_table.sv
/*
 * Branch target buffer storage kept in most-recently-used order.
 * An update is written at the front and older lines shift down behind it.
 * A pre-decoded update never overrides a line learned from an executed jump.
 */

`default_nettype none

module bp_btb_table (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_flush,
    input  bp_pkg::bp_update_t     i_upd,
    output bp_pkg::btb_table_t     o_table
);

    bp_pkg::btb_table_t                r_table;
    bp_pkg::btb_table_t                table_nxt;
    logic [bp_pkg::BTB_SIZE-1:0]       pc_equal;    // Line holds the update's source
    logic [bp_pkg::BTB_SIZE-1:0]       keep;        // Line sits below the old copy
    logic                              dont_update;
    logic                              do_write;

    // Search the table for the update address
    always_comb begin
        dont_update = 1'b0;
        for (int i = 0; i < bp_pkg::BTB_SIZE; i++) begin
            pc_equal[i] = (r_table[i].pc == i_upd.pc);
            if (pc_equal[i] && r_table[i].exec && !i_upd.e) begin
                dont_update = 1'b1;    // Executed target wins over a pre-decoded guess
            end
        end
    end

    // Lines past the matching one are not part of the shift
    always_comb begin
        keep[0] = 1'b0;
        for (int i = 1; i < bp_pkg::BTB_SIZE; i++) begin
            keep[i] = keep[i-1] | pc_equal[i-1];
        end
    end

    assign do_write = i_upd.we & ~dont_update;

    // Move-to-front insertion
    always_comb begin
        table_nxt = r_table;
        if (do_write) begin
            table_nxt[0].pc   = i_upd.pc;
            table_nxt[0].npc  = i_upd.npc;
            table_nxt[0].exec = i_upd.e;
            for (int i = 1; i < bp_pkg::BTB_SIZE; i++) begin
                if (!keep[i]) begin
                    table_nxt[i] = r_table[i-1];    // The old copy is overwritten here
                end
            end
        end
    end

    // On a miss the oldest line falls off the end of the shift
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < bp_pkg::BTB_SIZE; i++) begin
                r_table[i] <= bp_pkg::BTB_ENTRY_RST;
            end
        end else if (i_flush) begin
            // Flush beats a write in the same cycle
            for (int i = 0; i < bp_pkg::BTB_SIZE; i++) begin
                r_table[i] <= bp_pkg::BTB_ENTRY_RST;
            end
        end else begin
            r_table <= table_nxt;
        end
    end

    assign o_table = r_table;

endmodule : bp_btb_table

`default_nettype wire

//--- rtl/bp_lookup_stage.sv
/*
 * One step of the prediction chain.
 * Looks one address up in every BTB line at once and returns the next address,
 * either the stored target or the fall-through address.
 */

`default_nettype none

module bp_lookup_stage (
    input  bp_pkg::btb_table_t  i_table,
    input  bp_pkg::addr_t       i_pc,
    output bp_pkg::bp_slot_t    o_slot,
    output logic                o_hit
);

    bp_pkg::addr_t  fall_through;

    assign fall_through = i_pc + bp_pkg::addr_t'(bp_pkg::INSN_BYTES);

    // Scan from the oldest line so that the most recent match is the last one applied
    always_comb begin
        o_hit       = 1'b0;
        o_slot.npc  = fall_through;    // Sequential fetch when nothing matches
        o_slot.exec = 1'b0;
        for (int n = bp_pkg::BTB_SIZE - 1; n >= 0; n--) begin
            if (i_table[n].pc == i_pc) begin
                o_hit       = 1'b1;
                o_slot.npc  = i_table[n].npc;
                o_slot.exec = i_table[n].exec;
            end
        end
    end

endmodule : bp_lookup_stage

`default_nettype wire

//--- rtl/bp_pkg.sv
/*
 * Sizes, address type and packed structs shared by the branch prediction unit.
 * Every module refers to these by scoped name.
 */

`default_nettype none

package bp_pkg;

    // Core and table geometry
    localparam int XLEN       = 32;
    localparam int BTB_SIZE   = 8;
    localparam int BP_DEPTH   = 4;   // Addresses per predicted sequence
    localparam int INSN_BYTES = 4;   // Fall-through step on a miss

    // Instruction address
    typedef logic [XLEN-1:0] addr_t;

    // One BTB line of 65 bits
    typedef struct packed {
        addr_t pc;      // Jump source
        addr_t npc;     // Jump target
        logic  exec;    // Learned from an executed jump
    } btb_entry_t;

    // Entry 0 is the most recently written
    typedef btb_entry_t [BTB_SIZE-1:0] btb_table_t;

    // Update request from the execute stage
    typedef struct packed {
        logic  we;      // Write request
        logic  e;       // Jump was executed, not only pre-decoded
        addr_t pc;
        addr_t npc;
    } bp_update_t;

    // One address of the predicted sequence
    typedef struct packed {
        addr_t npc;
        logic  exec;
    } bp_slot_t;

    // Slot 0 holds the start address
    typedef bp_slot_t [BP_DEPTH-1:0] bp_seq_t;

    // Empty line whose pc never matches a fetch address
    localparam btb_entry_t BTB_ENTRY_RST = '{pc: '1, npc: '0, exec: 1'b0};

endpackage : bp_pkg

`default_nettype wire

//--- rtl/bp_predictor.sv
/*
 * Branch-target prediction unit for the fetch stage.
 * The BTB feeds a chain of lookup stages that turns a start address into
 * BP_DEPTH predicted addresses, returned one cycle later through a valid/ready port.
 */

`default_nettype none

module bp_predictor (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  logic                         i_flush,
    input  bp_pkg::bp_update_t           i_upd,
    input  logic                         i_bp_req,
    input  bp_pkg::addr_t                i_bp_pc,
    output logic                         o_bp_req_ready,
    output logic                         o_bp_valid,
    output bp_pkg::bp_seq_t              o_bp_seq,
    output logic [bp_pkg::BP_DEPTH-1:0]  o_bp_hit,
    input  logic                         i_bp_ready
);

    bp_pkg::btb_table_t                btb;
    bp_pkg::bp_seq_t                   chain_seq;   // Combinational prediction
    logic [bp_pkg::BP_DEPTH-1:0]       chain_hit;

    bp_btb_table i_btb_table (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_flush (i_flush),
        .i_upd   (i_upd),
        .o_table (btb)
    );

    // Slot 0 is the fetch address itself and never counts as a hit
    assign chain_seq[0].npc  = i_bp_pc;
    assign chain_seq[0].exec = 1'b0;
    assign chain_hit[0]      = 1'b0;

    // Each stage follows the address produced by the one before it
    for (genvar k = 1; k < bp_pkg::BP_DEPTH; k++) begin : g_stage
        bp_lookup_stage i_lookup (
            .i_table (btb),
            .i_pc    (chain_seq[k-1].npc),
            .o_slot  (chain_seq[k]),
            .o_hit   (chain_hit[k])
        );
    end

    bp_seq_out i_seq_out (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req       (i_bp_req),
        .i_seq       (chain_seq),
        .i_hit       (chain_hit),
        .o_req_ready (o_bp_req_ready),
        .o_valid     (o_bp_valid),
        .o_seq       (o_bp_seq),
        .o_hit       (o_bp_hit),
        .i_ready     (i_bp_ready)
    );

endmodule : bp_predictor

`default_nettype wire

//--- rtl/bp_seq_out.sv
/*
 * Output register of the predictor with a valid/ready handshake.
 * A request is taken only when the register is free or being drained,
 * and the stored sequence stays put while the consumer stalls.
 */

`default_nettype none

module bp_seq_out (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  logic                         i_req,
    input  bp_pkg::bp_seq_t              i_seq,
    input  logic [bp_pkg::BP_DEPTH-1:0]  i_hit,
    output logic                         o_req_ready,
    output logic                         o_valid,
    output bp_pkg::bp_seq_t              o_seq,
    output logic [bp_pkg::BP_DEPTH-1:0]  o_hit,
    input  logic                         i_ready
);

    logic                         r_valid;
    bp_pkg::bp_seq_t              r_seq;
    logic [bp_pkg::BP_DEPTH-1:0]  r_hit;
    logic                         accept;

    // Blocked only by a response that is still waiting
    assign o_req_ready = ~(r_valid & ~i_ready);
    assign accept      = i_req & o_req_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (i_ready) begin
            r_valid <= 1'b0;            // Drained with nothing behind it
        end
    end

    // Sequence and hit bits are loaded together so they describe the same request
    always_ff @(posedge i_clk) begin
        if (accept) begin
            r_seq <= i_seq;
            r_hit <= i_hit;
        end
    end

    assign o_valid = r_valid;
    assign o_seq   = r_seq;
    assign o_hit   = r_hit;

endmodule : bp_seq_out

`default_nettype wire
